//--- logic/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder (
    input  logic                    CK_REF,
    input  logic                    RST_N,
    input  isa_pkg::word_t          instruction,
    input  isa_pkg::word_t          rs1_data,
    input  isa_pkg::word_t          rs2_data,
    input  isa_pkg::reg_addr_t      rd_offset_1c,     // dest one stage ahead
    input  isa_pkg::reg_addr_t      rd_offset_2c,
    input  isa_pkg::reg_addr_t      rd_offset_3c,
    input  isa_pkg::word_t          alu_out_comb,     // result of the 1c producer
    input  isa_pkg::word_t          alu_output,       // 2c producer
    input  isa_pkg::word_t          alu_out_reg_1c,   // 3c producer
    output logic                    update_pc_next,
    output isa_pkg::reg_addr_t      rd_offset_next,
    output isa_pkg::reg_addr_t      rs1_offset,
    output isa_pkg::reg_addr_t      rs2_offset,
    output isa_pkg::word_t          alu_input_a,
    output isa_pkg::word_t          alu_input_b,
    output pipe_ctrl_pkg::alu_op_t  alu_op,
    output pipe_ctrl_pkg::mem_op_t  mem_op_next,
    output logic                    alu_mem_sel_next,
    output logic                    reg_wb_next,
    output pipe_ctrl_pkg::wb_type_t wb_type_next,
    output isa_pkg::word_t          store_data_next
);

    isa_pkg::word_t fwd_a;
    isa_pkg::word_t fwd_b;
    logic           first_cycle;

    // rs1 path
    operand_forward fwd_rs1 (
        .src_offset   (rs1_offset),
        .rf_data      (rs1_data),
        .rd_offset_1c (rd_offset_1c),
        .rd_offset_2c (rd_offset_2c),
        .rd_offset_3c (rd_offset_3c),
        .fwd_1c       (alu_out_comb),
        .fwd_2c       (alu_output),
        .fwd_3c       (alu_out_reg_1c),
        .operand      (fwd_a)
    );

    // rs2 path, same taps
    operand_forward fwd_rs2 (
        .src_offset   (rs2_offset),
        .rf_data      (rs2_data),
        .rd_offset_1c (rd_offset_1c),
        .rd_offset_2c (rd_offset_2c),
        .rd_offset_3c (rd_offset_3c),
        .fwd_1c       (alu_out_comb),
        .fwd_2c       (alu_output),
        .fwd_3c       (alu_out_reg_1c),
        .operand      (fwd_b)
    );

    jump_hold u_jump_hold (
        .CK_REF      (CK_REF),
        .RST_N       (RST_N),
        .instruction (instruction),
        .first_cycle (first_cycle)
    );

    opcode_decode u_opcode_decode (
        .instruction      (instruction),
        .fwd_a            (fwd_a),
        .fwd_b            (fwd_b),
        .rs2_data         (rs2_data),
        .first_cycle      (first_cycle),
        .update_pc_next   (update_pc_next),
        .rd_offset_next   (rd_offset_next),
        .rs1_offset       (rs1_offset),
        .rs2_offset       (rs2_offset),
        .alu_input_a      (alu_input_a),
        .alu_input_b      (alu_input_b),
        .alu_op           (alu_op),
        .mem_op_next      (mem_op_next),
        .alu_mem_sel_next (alu_mem_sel_next),
        .reg_wb_next      (reg_wb_next),
        .wb_type_next     (wb_type_next),
        .store_data_next  (store_data_next)
    );

endmodule

//--- logic/isa_pkg.sv
package isa_pkg;

    localparam int xlen       = 32;   // data and instruction width
    localparam int reg_addr_w = 5;    // 32 architectural registers
    localparam int opc_w      = 7;
    localparam int funct3_w   = 3;
    localparam int imm_w      = 12;   // i-type and s-type immediate width

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // major opcodes, instruction bits 6..0
    localparam logic [opc_w-1:0] opc_op     = 7'b011_0011;  // register-register alu
    localparam logic [opc_w-1:0] opc_op_imm = 7'b001_0011;  // register-immediate alu
    localparam logic [opc_w-1:0] opc_load   = 7'b000_0011;
    localparam logic [opc_w-1:0] opc_store  = 7'b010_0011;
    localparam logic [opc_w-1:0] opc_jal    = 7'b110_1111;
    localparam logic [opc_w-1:0] opc_jalr   = 7'b110_0111;  // only seen by the hold counter
    localparam logic [opc_w-1:0] opc_branch = 7'b110_0011;  // same
    localparam logic [opc_w-1:0] opc_bubble = 7'b000_0000;  // upstream stall word

    // load widths
    localparam logic [funct3_w-1:0] f3_lb  = 3'b000;
    localparam logic [funct3_w-1:0] f3_lh  = 3'b001;
    localparam logic [funct3_w-1:0] f3_lw  = 3'b010;
    localparam logic [funct3_w-1:0] f3_lbu = 3'b100;
    localparam logic [funct3_w-1:0] f3_lhu = 3'b101;

    // store widths
    localparam logic [funct3_w-1:0] f3_sb = 3'b000;
    localparam logic [funct3_w-1:0] f3_sh = 3'b001;
    localparam logic [funct3_w-1:0] f3_sw = 3'b010;

    // alu variants, shared by OP and OP-IMM
    localparam logic [funct3_w-1:0] f3_add_sub = 3'b000;
    localparam logic [funct3_w-1:0] f3_sll     = 3'b001;
    localparam logic [funct3_w-1:0] f3_slt     = 3'b010;
    localparam logic [funct3_w-1:0] f3_sltu    = 3'b011;
    localparam logic [funct3_w-1:0] f3_xor     = 3'b100;
    localparam logic [funct3_w-1:0] f3_srl_sra = 3'b101;
    localparam logic [funct3_w-1:0] f3_or      = 3'b110;
    localparam logic [funct3_w-1:0] f3_and     = 3'b111;

    // field positions
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;   // also the low end of the u/j upper field
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int imm_i_lsb  = 20;
    localparam int imm_s_lsb  = 25;   // upper part of the s immediate
    localparam int alt_bit    = 30;   // picks sub and sra

endpackage

//--- logic/jump_hold.sv
`timescale 1ns/1ps

module jump_hold (
    input  logic           CK_REF,
    input  logic           RST_N,
    input  isa_pkg::word_t instruction,   // word sitting in decode
    output logic           first_cycle    // high only while no jump has been counted yet
);

    logic [isa_pkg::opc_w-1:0] opcode;
    logic                      is_jump;
    pipe_ctrl_pkg::jump_cnt_t  hold_cnt;   // edges the current jump has sat in decode

    assign opcode = instruction[isa_pkg::opc_w-1:0];

    // every pc-changing opcode counts, even those decode ignores
    assign is_jump = (opcode == isa_pkg::opc_jal)  ||
                     (opcode == isa_pkg::opc_jalr) ||
                     (opcode == isa_pkg::opc_branch);

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            hold_cnt <= '0;
        end else if (!is_jump) begin
            hold_cnt <= '0;                        // next jump pulses again
        end else if (hold_cnt != pipe_ctrl_pkg::jump_hold_max) begin
            hold_cnt <= hold_cnt + 1'b1;           // saturate, no wrap back to zero
        end
    end

    // a held jump sees zero only before its first edge
    assign first_cycle = (hold_cnt == '0);

endmodule

//--- logic/opcode_decode.sv
`timescale 1ns/1ps

module opcode_decode (
    input  isa_pkg::word_t          instruction,
    input  isa_pkg::word_t          fwd_a,             // rs1 after forwarding
    input  isa_pkg::word_t          fwd_b,             // rs2 after forwarding
    input  isa_pkg::word_t          rs2_data,          // raw file data for the store path
    input  logic                    first_cycle,       // from the hold counter
    output logic                    update_pc_next,
    output isa_pkg::reg_addr_t      rd_offset_next,
    output isa_pkg::reg_addr_t      rs1_offset,
    output isa_pkg::reg_addr_t      rs2_offset,
    output isa_pkg::word_t          alu_input_a,
    output isa_pkg::word_t          alu_input_b,
    output pipe_ctrl_pkg::alu_op_t  alu_op,
    output pipe_ctrl_pkg::mem_op_t  mem_op_next,
    output logic                    alu_mem_sel_next,  // 1 = write back alu result
    output logic                    reg_wb_next,
    output pipe_ctrl_pkg::wb_type_t wb_type_next,
    output isa_pkg::word_t          store_data_next
);

    logic [isa_pkg::opc_w-1:0]    opcode;
    logic [isa_pkg::funct3_w-1:0] funct3;
    logic                         alt;          // bit 30
    isa_pkg::reg_addr_t           rd_fld;
    isa_pkg::reg_addr_t           rs1_fld;
    isa_pkg::reg_addr_t           rs2_fld;
    isa_pkg::word_t               imm_i;
    isa_pkg::word_t               imm_s;
    isa_pkg::word_t               jal_upper;
    logic                         is_op;
    pipe_ctrl_pkg::alu_op_t       alu_sel;      // funct3 decode shared by OP and OP-IMM

    // instruction fields
    assign opcode  = instruction[isa_pkg::opc_w-1:0];
    assign funct3  = instruction[isa_pkg::funct3_lsb +: isa_pkg::funct3_w];
    assign alt     = instruction[isa_pkg::alt_bit];
    assign rd_fld  = instruction[isa_pkg::rd_lsb +: isa_pkg::reg_addr_w];
    assign rs1_fld = instruction[isa_pkg::rs1_lsb +: isa_pkg::reg_addr_w];
    assign rs2_fld = instruction[isa_pkg::rs2_lsb +: isa_pkg::reg_addr_w];

    // i-type immediate sign-extended from 12 bits
    assign imm_i = {{(isa_pkg::xlen-isa_pkg::imm_w){instruction[isa_pkg::xlen-1]}},
                    instruction[isa_pkg::xlen-1:isa_pkg::imm_i_lsb]};

    // s-type immediate split around rs2 and rs1 with its low part in the rd field
    assign imm_s = {{(isa_pkg::xlen-isa_pkg::imm_w){instruction[isa_pkg::xlen-1]}},
                    instruction[isa_pkg::xlen-1:isa_pkg::imm_s_lsb],
                    instruction[isa_pkg::rd_lsb +: isa_pkg::reg_addr_w]};

    // jal upper field zero-extended as is
    assign jal_upper = {{isa_pkg::imm_w{1'b0}},
                        instruction[isa_pkg::xlen-1:isa_pkg::funct3_lsb]};

    assign is_op = (opcode == isa_pkg::opc_op);

    always_comb begin
        case (funct3)
            isa_pkg::f3_add_sub: begin
                // addi ignores bit 30 since only the register form has sub
                alu_sel = (is_op && alt) ? pipe_ctrl_pkg::alu_sub : pipe_ctrl_pkg::alu_add;
            end
            isa_pkg::f3_sll:  alu_sel = pipe_ctrl_pkg::alu_sll;
            isa_pkg::f3_slt:  alu_sel = pipe_ctrl_pkg::alu_slt;
            isa_pkg::f3_sltu: alu_sel = pipe_ctrl_pkg::alu_sltu;
            isa_pkg::f3_xor:  alu_sel = pipe_ctrl_pkg::alu_xor;
            isa_pkg::f3_srl_sra: begin
                alu_sel = alt ? pipe_ctrl_pkg::alu_sra : pipe_ctrl_pkg::alu_srl;
            end
            isa_pkg::f3_or:   alu_sel = pipe_ctrl_pkg::alu_or;
            isa_pkg::f3_and:  alu_sel = pipe_ctrl_pkg::alu_and;
        endcase
    end

    always_comb begin
        // inactive defaults as produced by a bubble
        update_pc_next   = 1'b0;
        rd_offset_next   = '0;
        rs1_offset       = '0;
        rs2_offset       = '0;
        alu_input_a      = '0;
        alu_input_b      = '0;
        alu_op           = pipe_ctrl_pkg::alu_nop;
        mem_op_next      = pipe_ctrl_pkg::mem_nop;
        alu_mem_sel_next = 1'b0;
        reg_wb_next      = 1'b0;
        wb_type_next     = pipe_ctrl_pkg::wb_word;
        store_data_next  = '0;

        case (opcode)
            isa_pkg::opc_op: begin
                rd_offset_next   = rd_fld;
                rs1_offset       = rs1_fld;
                rs2_offset       = rs2_fld;
                alu_input_a      = fwd_a;
                alu_input_b      = fwd_b;
                alu_op           = alu_sel;
                alu_mem_sel_next = 1'b1;
                reg_wb_next      = 1'b1;
            end
            isa_pkg::opc_op_imm: begin
                rd_offset_next   = rd_fld;
                rs1_offset       = rs1_fld;   // rs2 stays 0 so b is never forwarded
                alu_input_a      = fwd_a;
                alu_input_b      = imm_i;     // shifts only use the low 5 bits
                alu_op           = alu_sel;
                alu_mem_sel_next = 1'b1;
                reg_wb_next      = 1'b1;
            end
            isa_pkg::opc_load: begin
                rd_offset_next   = rd_fld;
                rs1_offset       = rs1_fld;
                alu_input_a      = fwd_a;     // base
                alu_input_b      = imm_i;     // offset
                alu_op           = pipe_ctrl_pkg::alu_add;
                mem_op_next      = pipe_ctrl_pkg::mem_load;
                alu_mem_sel_next = 1'b0;      // write back from memory
                reg_wb_next      = 1'b1;
                case (funct3)
                    isa_pkg::f3_lb:  wb_type_next = pipe_ctrl_pkg::wb_byte_signed;
                    isa_pkg::f3_lh:  wb_type_next = pipe_ctrl_pkg::wb_half_signed;
                    isa_pkg::f3_lw:  wb_type_next = pipe_ctrl_pkg::wb_word;
                    isa_pkg::f3_lbu: wb_type_next = pipe_ctrl_pkg::wb_byte_unsigned;
                    isa_pkg::f3_lhu: wb_type_next = pipe_ctrl_pkg::wb_half_unsigned;
                    default:         wb_type_next = pipe_ctrl_pkg::wb_word;
                endcase
            end
            isa_pkg::opc_store: begin
                rs1_offset      = rs1_fld;
                rs2_offset      = rs2_fld;
                alu_input_a     = fwd_a;
                alu_input_b     = imm_s;
                alu_op          = pipe_ctrl_pkg::alu_add;
                mem_op_next     = pipe_ctrl_pkg::mem_store;
                store_data_next = rs2_data;    // raw file data without forwarding
                // width tells the memory stage how many bytes to write
                case (funct3)
                    isa_pkg::f3_sb: wb_type_next = pipe_ctrl_pkg::wb_byte_signed;
                    isa_pkg::f3_sh: wb_type_next = pipe_ctrl_pkg::wb_half_signed;
                    isa_pkg::f3_sw: wb_type_next = pipe_ctrl_pkg::wb_word;
                    default:        wb_type_next = pipe_ctrl_pkg::wb_word;
                endcase
            end
            isa_pkg::opc_jal: begin
                update_pc_next   = first_cycle;   // one pulse however long it sits here
                rd_offset_next   = rd_fld;
                alu_input_a      = jal_upper;
                alu_input_b      = '0;
                alu_op           = pipe_ctrl_pkg::alu_add;
                alu_mem_sel_next = 1'b1;
                reg_wb_next      = 1'b1;          // link value stays valid every cycle
            end
            isa_pkg::opc_bubble: begin
                // stall slot from upstream keeps every field inactive
            end
            default: begin
                // lui, auipc, jalr, branch, fence, system and unknown codes
            end
        endcase
    end

endmodule

//--- logic/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
    input  isa_pkg::reg_addr_t src_offset,     // source register being read
    input  isa_pkg::word_t     rf_data,        // register file read data
    input  isa_pkg::reg_addr_t rd_offset_1c,   // dest of the instruction one stage ahead
    input  isa_pkg::reg_addr_t rd_offset_2c,
    input  isa_pkg::reg_addr_t rd_offset_3c,   // oldest one still in flight
    input  isa_pkg::word_t     fwd_1c,         // result tap matching rd_offset_1c
    input  isa_pkg::word_t     fwd_2c,
    input  isa_pkg::word_t     fwd_3c,
    output isa_pkg::word_t     operand
);

    logic src_valid;
    logic hit_1c;
    logic hit_2c;
    logic hit_3c;

    // x0 reads as zero from the file, a write to it must never be forwarded
    assign src_valid = (src_offset != '0);

    assign hit_1c = src_valid && (src_offset == rd_offset_1c);
    assign hit_2c = src_valid && (src_offset == rd_offset_2c);
    assign hit_3c = src_valid && (src_offset == rd_offset_3c);

    // nearest producer holds the newest value of the register
    always_comb begin
        if (hit_1c) begin
            operand = fwd_1c;            // still in the alu this cycle
        end else if (hit_2c) begin
            operand = fwd_2c;            // alu output register
        end else if (hit_3c) begin
            operand = fwd_3c;            // one register further down
        end else begin
            operand = rf_data;           // no hazard, file data is current
        end
    end

endmodule

//--- logic/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    localparam int alu_op_w    = 4;
    localparam int mem_op_w    = 2;
    localparam int wb_type_w   = 3;
    localparam int jump_cnt_w  = 3;

    // alu operation handed to execute
    typedef enum logic [alu_op_w-1:0] {
        alu_nop  = 4'd0,   // inactive, also the bubble value
        alu_add  = 4'd1,
        alu_sub  = 4'd2,
        alu_sll  = 4'd3,
        alu_slt  = 4'd4,
        alu_sltu = 4'd5,
        alu_xor  = 4'd6,
        alu_srl  = 4'd7,
        alu_sra  = 4'd8,
        alu_or   = 4'd9,
        alu_and  = 4'd10
    } alu_op_t;

    // memory stage action
    typedef enum logic [mem_op_w-1:0] {
        mem_nop   = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_t;

    // access width and extension, used by memory and write-back
    typedef enum logic [wb_type_w-1:0] {
        wb_word          = 3'd0,   // inactive default
        wb_half_signed   = 3'd1,
        wb_half_unsigned = 3'd2,
        wb_byte_signed   = 3'd3,
        wb_byte_unsigned = 3'd4
    } wb_type_t;

    typedef logic [jump_cnt_w-1:0] jump_cnt_t;

    // hold counter stops here, a jump never sits in decode longer than this
    localparam jump_cnt_t jump_hold_max = 3'd5;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_instruction_decoder \
    -f sources.f -o sim_decoder \
    || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/sim_decoder) \
    || { echo "$sim_out"; echo "simulation did not complete"; exit 1; }

echo "$sim_out"
echo "$sim_out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

//--- sources.f
logic/isa_pkg.sv
logic/pipe_ctrl_pkg.sv
logic/operand_forward.sv
logic/jump_hold.sv
logic/opcode_decode.sv
logic/instruction_decoder.sv
testbench/decode_checker.sv
testbench/tb_instruction_decoder.sv

//--- testbench/decode_checker.sv
`timescale 1ns/1ps

module decode_checker (
    input  logic        CK_REF,
    input  logic        check_en,          // a vector is on the DUT inputs
    input  logic        test_end,          // this rising edge closes the running test
    input  int          test_id,
    input  logic        exp_pc,
    input  logic [4:0]  exp_rd,
    input  logic [4:0]  exp_rs1,
    input  logic [4:0]  exp_rs2,
    input  logic [31:0] exp_a,
    input  logic [31:0] exp_b,
    input  logic [3:0]  exp_op,
    input  logic [1:0]  exp_mem,
    input  logic        exp_sel,
    input  logic        exp_wb,
    input  logic [2:0]  exp_wbt,
    input  logic [31:0] exp_st,
    input  logic        update_pc_next,
    input  logic [4:0]  rd_offset_next,
    input  logic [4:0]  rs1_offset,
    input  logic [4:0]  rs2_offset,
    input  logic [31:0] alu_input_a,
    input  logic [31:0] alu_input_b,
    input  logic [3:0]  alu_op,
    input  logic [1:0]  mem_op_next,
    input  logic        alu_mem_sel_next,
    input  logic        reg_wb_next,
    input  logic [2:0]  wb_type_next,
    input  logic [31:0] store_data_next,
    output int          pass_count,
    output int          fail_count
);

    int n_pass = 0;
    int n_fail = 0;
    int err_cnt = 0;   // mismatches in the running test

    assign pass_count = n_pass;
    assign fail_count = n_fail;

    // one field, reported at the edge where it goes wrong
    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (got !== exp) begin
            $display("error at time %0t: test %0d, %s expected %h got %h",
                     $time, test_id, name, exp, got);
            err_cnt++;
        end
    endtask

    // inputs change on the falling edge, so they are settled here
    always @(posedge CK_REF) begin
        if (check_en) begin
            check_field("update_pc_next",   32'(exp_pc),  32'(update_pc_next));
            check_field("rd_offset_next",   32'(exp_rd),  32'(rd_offset_next));
            check_field("rs1_offset",       32'(exp_rs1), 32'(rs1_offset));
            check_field("rs2_offset",       32'(exp_rs2), 32'(rs2_offset));
            check_field("alu_input_a",      exp_a,        alu_input_a);
            check_field("alu_input_b",      exp_b,        alu_input_b);
            check_field("alu_op",           32'(exp_op),  32'(alu_op));
            check_field("mem_op_next",      32'(exp_mem), 32'(mem_op_next));
            check_field("alu_mem_sel_next", 32'(exp_sel), 32'(alu_mem_sel_next));
            check_field("reg_wb_next",      32'(exp_wb),  32'(reg_wb_next));
            check_field("wb_type_next",     32'(exp_wbt), 32'(wb_type_next));
            check_field("store_data_next",  exp_st,       store_data_next);
            if (test_end) begin
                if (err_cnt == 0) begin
                    $display("test %0d ok", test_id);
                    n_pass++;
                end else begin
                    $display("test %0d failed with %0d mismatches", test_id, err_cnt);
                    n_fail++;
                end
                err_cnt = 0;   // next test starts clean
            end
        end
    end

endmodule

//--- testbench/decode_input.txt
# id rpt(dec) instr rs1_data rs2_data rd_1c rd_2c rd_3c alu_out_comb alu_output alu_out_reg_1c
# then expected: update_pc rd rs1 rs2 alu_a alu_b alu_op mem_op alu_mem_sel reg_wb wb_type store
1  2 00000000 1111 2222 1d 1e 1f aaaa bbbb cccc  0 0 0 0 0 0 0 0 0 0 0 0
2  1 002081b3 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 2 1111 2222 1 0 1 1 0 0
3  1 402081b3 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 2 1111 2222 2 0 1 1 0 0
4  1 002091b3 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 2 1111 2222 3 0 1 1 0 0
5  1 0020a1b3 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 2 1111 2222 4 0 1 1 0 0
6  1 0020b1b3 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 2 1111 2222 5 0 1 1 0 0
7  1 0020c1b3 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 2 1111 2222 6 0 1 1 0 0
8  1 0020d1b3 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 2 1111 2222 7 0 1 1 0 0
9  1 4020d1b3 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 2 1111 2222 8 0 1 1 0 0
10 1 0020e1b3 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 2 1111 2222 9 0 1 1 0 0
11 1 0020f1b3 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 2 1111 2222 a 0 1 1 0 0
12 1 ff008193 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 fffffff0 1 0 1 1 0 0
13 1 00509193 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 5 3 0 1 1 0 0
14 1 7ff0a193 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 7ff 4 0 1 1 0 0
15 1 fff0b193 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 ffffffff 5 0 1 1 0 0
16 1 1230c193 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 123 6 0 1 1 0 0
17 1 0030d193 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 3 7 0 1 1 0 0
18 1 4030d193 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 403 8 0 1 1 0 0
19 1 8000e193 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 fffff800 9 0 1 1 0 0
20 1 0ff0f193 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 ff a 0 1 1 0 0
21 1 ffc08183 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 fffffffc 1 1 0 1 3 0
22 1 00809183 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 8 1 1 0 1 1 0
23 1 7fc0a183 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 7fc 1 1 0 1 0 0
24 1 0010c183 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 1 1 1 0 1 4 0
25 1 ffe0d183 1111 2222 1d 1e 1f aaaa bbbb cccc  0 3 1 0 1111 fffffffe 1 1 0 1 2 0
26 1 fe208c23 1111 2222 1d 1e 1f aaaa bbbb cccc  0 0 1 2 1111 fffffff8 1 2 0 0 3 2222
27 1 02209223 1111 2222 1d 1e 1f aaaa bbbb cccc  0 0 1 2 1111 24 1 2 0 0 1 2222
28 1 7e20afa3 1111 2222 1d 1e 1f aaaa bbbb cccc  0 0 1 2 1111 7ff 1 2 0 0 0 2222
29 1 002081b3 1111 2222 1 1 1 aaaa bbbb cccc  0 3 1 2 aaaa 2222 1 0 1 1 0 0
30 1 002081b3 1111 2222 1d 2 1 aaaa bbbb cccc  0 3 1 2 cccc bbbb 1 0 1 1 0 0
31 1 000001b3 1111 2222 0 0 0 aaaa bbbb cccc  0 3 0 0 1111 2222 1 0 1 1 0 0
32 1 7e20afa3 1111 2222 2 1 1f aaaa bbbb cccc  0 0 1 2 bbbb 7ff 1 2 0 0 0 2222
33 1 123452ef 1111 2222 1d 1e 1f aaaa bbbb cccc  1 5 0 0 12345 0 1 0 1 1 0 0
34 5 123452ef 1111 2222 1d 1e 1f aaaa bbbb cccc  0 5 0 0 12345 0 1 0 1 1 0 0
35 1 00000000 1111 2222 1d 1e 1f aaaa bbbb cccc  0 0 0 0 0 0 0 0 0 0 0 0
36 1 fedcb0ef 1111 2222 1d 1e 1f aaaa bbbb cccc  1 1 0 0 fedcb 0 1 0 1 1 0 0
37 1 123452b7 1111 2222 1d 1e 1f aaaa bbbb cccc  0 0 0 0 0 0 0 0 0 0 0 0
38 1 0ff0000f 1111 2222 1d 1e 1f aaaa bbbb cccc  0 0 0 0 0 0 0 0 0 0 0 0
39 1 0020817f 1111 2222 1d 1e 1f aaaa bbbb cccc  0 0 0 0 0 0 0 0 0 0 0 0

//--- testbench/tb_instruction_decoder.sv
`timescale 1ns/1ps

module tb_instruction_decoder;

    localparam int half_period  = 4;    // 8 ns clock
    localparam int reset_cycles = 16;
    localparam int spare_cycles = 20;   // margin on top of the vector cycles

    logic        CK_REF = 1'b0;
    logic        RST_N;
    logic [31:0] instruction, rs1_data, rs2_data;
    logic [4:0]  rd_offset_1c, rd_offset_2c, rd_offset_3c;
    logic [31:0] alu_out_comb, alu_output, alu_out_reg_1c;

    logic        update_pc_next, alu_mem_sel_next, reg_wb_next;
    logic [4:0]  rd_offset_next, rs1_offset, rs2_offset;
    logic [31:0] alu_input_a, alu_input_b, store_data_next;
    logic [3:0]  alu_op;
    logic [1:0]  mem_op_next;
    logic [2:0]  wb_type_next;

    // expected fields of the current vector
    logic        exp_pc, exp_sel, exp_wb;
    logic [4:0]  exp_rd, exp_rs1, exp_rs2;
    logic [31:0] exp_a, exp_b, exp_st;
    logic [3:0]  exp_op;
    logic [1:0]  exp_mem;
    logic [2:0]  exp_wbt;

    logic        check_en;
    logic        test_end;
    int          test_id;
    int          rpt;
    string       vectors[$];        // raw lines, parsed again when applied
    int          total_cycles = 0;
    int          cycle_limit = 0;
    int          cycle_cnt = 0;
    bit          load_ok;
    int          fields;
    int          pass_count, fail_count;

    instruction_decoder UUT (.*);

    decode_checker u_checker (.*);

    always #half_period CK_REF = ~CK_REF;

    // cycle counter, stops a run that overruns the vector length
    always @(posedge CK_REF) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout, run did not end within %0d clock cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // fills inputs and expected fields from one line, fields = count read
    task automatic parse_vector(input string line, output int n);
        n = $sscanf(line,
            "%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            test_id, rpt, instruction, rs1_data, rs2_data,
            rd_offset_1c, rd_offset_2c, rd_offset_3c,
            alu_out_comb, alu_output, alu_out_reg_1c,
            exp_pc, exp_rd, exp_rs1, exp_rs2, exp_a, exp_b,
            exp_op, exp_mem, exp_sel, exp_wb, exp_wbt, exp_st);
    endtask

    task automatic load_vectors(output bit ok);
        int    fd;
        int    n;
        string line;
        ok = 1'b1;
        fd = $fopen("testbench/decode_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/decode_input.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                parse_vector(line, n);
                if (n == 23 && rpt > 0) begin
                    vectors.push_back(line);
                    total_cycles += rpt;
                end else if (n > 0) begin   // comments and blank lines read nothing
                    $display("malformed vector line: %s", line);
                    ok = 1'b0;
                end
            end
            $fclose(fd);
            if (vectors.size() == 0) begin
                $display("stimulus file holds no vectors");
                ok = 1'b0;
            end
        end
    endtask

    // bubble on every input while reset is low
    task automatic init_inputs();
        instruction    = '0;
        rs1_data       = '0;
        rs2_data       = '0;
        rd_offset_1c   = '0;
        rd_offset_2c   = '0;
        rd_offset_3c   = '0;
        alu_out_comb   = '0;
        alu_output     = '0;
        alu_out_reg_1c = '0;
        check_en       = 1'b0;
        test_end       = 1'b0;
        test_id        = 0;
    endtask

    initial begin
        load_vectors(load_ok);
        init_inputs();
        RST_N = 1'b0;
        cycle_limit = total_cycles + reset_cycles + spare_cycles;
        if (!load_ok) begin
            $display("no tests were run, stimulus file could not be used");
            $display("*** FAILED ***");
            $finish;
        end else begin
            repeat (reset_cycles) @(negedge CK_REF);
            RST_N = 1'b1;
            foreach (vectors[i]) begin
                parse_vector(vectors[i], fields);   // drive on the falling edge
                check_en = 1'b1;
                for (int r = 0; r < rpt; r++) begin
                    test_end = (r == rpt - 1);
                    @(negedge CK_REF);
                end
            end
            check_en = 1'b0;
            test_end = 1'b0;
            $display("tests passed %0d, failed %0d", pass_count, fail_count);
            if (fail_count == 0 && pass_count == vectors.size()) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule
